/* logic/cpu_cfg_pkg.sv */
// Back-end machine configuration

package cpu_cfg_pkg;

   // Datapath
   localparam int data_w       = 64;  // Operands and immediates
   localparam int pc_w         = 30;  // Word-addressed PC

   // Physical register file
   localparam int prf_aw       = 6;
   localparam int prf_depth    = 1 << prf_aw;

   // Reorder buffer indexing
   localparam int rob_id_w     = 4;
   localparam int rob_bank_w   = 2;

   // Issue width of the back end
   localparam int issue_lanes  = 2;

   // Two source operands per lane, each with its own read port
   localparam int prf_rd_ports = issue_lanes * 2;

   // Front-end exception flags carried with each uop
   localparam int fe_w         = 3;

endpackage

/* logic/phys_reg_file.sv */
// Physical register file
`timescale 1ns/1ps

module phys_reg_file
(
   input  logic                                                           clk,
   input  logic                                                           rst_n,
   // Synchronous read ports, two per lane
   input  logic [cpu_cfg_pkg::prf_rd_ports-1:0]                           rd_en,
   input  logic [cpu_cfg_pkg::prf_rd_ports-1:0][cpu_cfg_pkg::prf_aw-1:0]  rd_addr,
   output logic [cpu_cfg_pkg::prf_rd_ports-1:0][cpu_cfg_pkg::data_w-1:0]  rd_data,
   // Writeback port
   input  uop_pkg::prf_wb_t                                               wb
);
   import cpu_cfg_pkg::*;

   logic [data_w-1:0] regs_q [prf_depth];
   logic              wb_we;

   // Register 0 is hardwired, so writes to it are dropped
   assign wb_we = wb.valid & (wb.addr != '0);

   // Value a port samples this cycle
   function automatic logic [data_w-1:0] rd_value(input logic [prf_aw-1:0] addr);
      logic [data_w-1:0] val;
      if (addr == '0)
         val = '0;
      else if (wb_we && (wb.addr == addr))
         val = wb.data;       // Forward the write in flight
      else
         val = regs_q[addr];
      return val;
   endfunction

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < prf_depth; r++)
            regs_q[r] <= '0;
      end
      else if (wb_we)
      begin
         regs_q[wb.addr] <= wb.data;
      end
   end

   // Output registers hold while their enable is low
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_data <= '0;
      end
      else
      begin
         for (int p = 0; p < prf_rd_ports; p++)
         begin
            if (rd_en[p])
               rd_data[p] <= rd_value(rd_addr[p]);
         end
      end
   end

endmodule

/* logic/reg_read_unit.sv */
// Register-read stage top
`timescale 1ns/1ps

module reg_read_unit
(
   input  logic                                                   clk,
   input  logic                                                   rst_n,
   input  logic                                                   flush,
   // From issue
   input  uop_pkg::rr_uop_t [cpu_cfg_pkg::issue_lanes-1:0]        ro_uop,
   input  logic [cpu_cfg_pkg::issue_lanes-1:0]                    ro_valid,
   output logic [cpu_cfg_pkg::issue_lanes-1:0]                    ro_ready,
   // Writeback into the register file
   input  uop_pkg::prf_wb_t                                       wb,
   // To execute
   output uop_pkg::ex_uop_t [cpu_cfg_pkg::issue_lanes-1:0]        ex_uop,
   output logic [cpu_cfg_pkg::issue_lanes-1:0]                    ex_valid,
   input  logic [cpu_cfg_pkg::issue_lanes-1:0]                    ex_ready
);
   import cpu_cfg_pkg::*;

   // Lane i owns read ports 2*i and 2*i+1
   logic [prf_rd_ports-1:0]              rf_rd_en;
   logic [prf_rd_ports-1:0][prf_aw-1:0]  rf_rd_addr;
   logic [prf_rd_ports-1:0][data_w-1:0]  rf_rd_data;

   for (genvar i = 0; i < issue_lanes; i++)
   begin : gen_lane
      rr_lane u_lane
      (
         .clk       (clk),
         .rst_n     (rst_n),
         .flush     (flush),
         .in_uop    (ro_uop[i]),
         .in_valid  (ro_valid[i]),
         .in_ready  (ro_ready[i]),
         .rd_en     (rf_rd_en[2*i +: 2]),
         .rd_addr   (rf_rd_addr[2*i +: 2]),
         .rd_data   (rf_rd_data[2*i +: 2]),
         .out_uop   (ex_uop[i]),
         .out_valid (ex_valid[i]),
         .out_ready (ex_ready[i])
      );
   end

   phys_reg_file u_prf
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_en   (rf_rd_en),
      .rd_addr (rf_rd_addr),
      .rd_data (rf_rd_data),
      .wb      (wb)        // Straight from the writeback bus
   );

endmodule

/* logic/rr_lane.sv */
// Register-read lane
`timescale 1ns/1ps

module rr_lane
(
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   flush,
   // From issue
   input  uop_pkg::rr_uop_t                       in_uop,
   input  logic                                   in_valid,
   output logic                                   in_ready,
   // Read port pair into the register file
   output logic [1:0]                             rd_en,
   output logic [1:0][cpu_cfg_pkg::prf_aw-1:0]    rd_addr,
   input  logic [1:0][cpu_cfg_pkg::data_w-1:0]    rd_data,
   // To execute
   output uop_pkg::ex_uop_t                       out_uop,
   output logic                                   out_valid,
   input  logic                                   out_ready
);
   import uop_pkg::*;

   logic       p_ce;          // Pipeline enable
   logic       valid_q;       // Lane holds a uop
   logic [1:0] re_q;          // Source read enables of the held uop
   ex_uop_t    ld_uop;
   ex_uop_t    pld_q;

   // Free slot, or the held uop leaves this cycle
   assign in_ready = ~flush & (~valid_q | out_ready);
   assign p_ce     = in_valid & in_ready;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         valid_q <= 1'b0;
      else if (flush)
         valid_q <= 1'b0;     // Drop whatever is held
      else if (p_ce)
         valid_q <= 1'b1;
      else if (out_ready)
         valid_q <= 1'b0;     // Drained with nothing behind it
   end

   // Non-operand fields of the incoming uop
   always_comb
   begin
      ld_uop            = '0;
      ld_uop.alu_opc    = in_uop.alu_opc;
      ld_uop.bru_opc    = in_uop.bru_opc;
      ld_uop.lsu_op     = in_uop.lsu_op;
      ld_uop.epu_op     = in_uop.epu_op;
      ld_uop.fe         = in_uop.fe;
      ld_uop.pc         = in_uop.pc;
      ld_uop.pred_taken = in_uop.pred_taken;
      ld_uop.pred_tgt   = in_uop.pred_tgt;
      ld_uop.imm        = in_uop.imm;
      ld_uop.prd        = in_uop.prd;
      ld_uop.prd_we     = in_uop.prd_we;
      ld_uop.rob_id     = in_uop.rob_id;
      ld_uop.rob_bank   = in_uop.rob_bank;
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         pld_q <= ld_uop;
         re_q  <= {in_uop.prs2_re, in_uop.prs1_re};
      end
   end

   // The register file read acts as this stage's second half
   assign rd_en[0]   = p_ce & in_uop.prs1_re;
   assign rd_en[1]   = p_ce & in_uop.prs2_re;
   assign rd_addr[0] = in_uop.prs1;
   assign rd_addr[1] = in_uop.prs2;

   // Read ports hold during a stall, so operands stay put
   always_comb
   begin
      out_uop          = pld_q;
      out_uop.operand1 = re_q[0] ? rd_data[0] : '0;   // Unread source gives zero
      out_uop.operand2 = re_q[1] ? rd_data[1] : '0;
   end

   assign out_valid = valid_q;

endmodule

/* logic/uop_pkg.sv */
// Micro-op types for register read

package uop_pkg;

   import cpu_cfg_pkg::*;

   // ALU operation
   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_SUB  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_SLL  = 4'd6,
      ALU_SRL  = 4'd7,
      ALU_SLT  = 4'd8
   } alu_opc_e;

   // Branch unit operation
   typedef enum logic [2:0] {
      BRU_NONE = 3'd0,
      BRU_JMP  = 3'd1,
      BRU_BEQ  = 3'd2,
      BRU_BNE  = 3'd3,
      BRU_BLT  = 3'd4,
      BRU_BGE  = 3'd5
   } bru_opc_e;

   // Renamed uop as it leaves the issue queue
   typedef struct packed {
      alu_opc_e                alu_opc;
      bru_opc_e                bru_opc;
      logic                    lsu_op;
      logic                    epu_op;
      logic [fe_w-1:0]         fe;
      logic [pc_w-1:0]         pc;
      logic                    pred_taken;
      logic [pc_w-1:0]         pred_tgt;
      logic [data_w-1:0]       imm;
      logic [prf_aw-1:0]       prd;
      logic                    prd_we;
      logic [prf_aw-1:0]       prs1;
      logic                    prs1_re;
      logic [prf_aw-1:0]       prs2;
      logic                    prs2_re;
      logic [rob_id_w-1:0]     rob_id;
      logic [rob_bank_w-1:0]   rob_bank;
   } rr_uop_t;

   // Uop handed to execute, sources replaced by their values
   typedef struct packed {
      alu_opc_e                alu_opc;
      bru_opc_e                bru_opc;
      logic                    lsu_op;
      logic                    epu_op;
      logic [fe_w-1:0]         fe;
      logic [pc_w-1:0]         pc;
      logic                    pred_taken;
      logic [pc_w-1:0]         pred_tgt;
      logic [data_w-1:0]       imm;
      logic [prf_aw-1:0]       prd;
      logic                    prd_we;
      logic [data_w-1:0]       operand1;
      logic [data_w-1:0]       operand2;
      logic [rob_id_w-1:0]     rob_id;
      logic [rob_bank_w-1:0]   rob_bank;
   } ex_uop_t;

   // Writeback into the register file
   typedef struct packed {
      logic                    valid;
      logic [prf_aw-1:0]       addr;
      logic [data_w-1:0]       data;
   } prf_wb_t;

endpackage

/* reg_read_unit.f */
logic/cpu_cfg_pkg.sv
logic/uop_pkg.sv
logic/rr_lane.sv
logic/phys_reg_file.sv
logic/reg_read_unit.sv
verif/reg_read_unit_assertions.sv
verif/reg_read_unit_tb.sv

/* run.sh */
#!/bin/sh
# Compile the register-read stage with its testbench and run it with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f reg_read_unit.f --top-module reg_read_unit_tb &&
./obj_dir/Vreg_read_unit_tb ||
{ echo "Simulation failed"; exit 1; }

/* verif/reg_read_unit_assertions.sv */
// Lane handshake assertions
`timescale 1ns/1ps

module reg_read_unit_assertions
(
   input logic                 clk,
   input logic                 rst_n,
   input logic                 flush,
   input logic [1:0]           rd_en,
   input uop_pkg::ex_uop_t     out_uop,
   input logic                 out_valid,
   input logic                 out_ready
);

   // Held uop and its operands sit still under back-pressure
   property hold_under_stall;
      @(posedge clk) disable iff (!rst_n)
         (out_valid && !out_ready) |=> $stable(out_uop);
   endproperty

   property empty_after_flush;
      @(posedge clk) disable iff (!rst_n)
         flush |=> !out_valid;
   endproperty

   // Reads start only for a uop the lane takes on
   property read_starts_uop;
      @(posedge clk) disable iff (!rst_n)
         (|rd_en) |=> out_valid;
   endproperty

   assert property (hold_under_stall)
   else $error("Lane output changed while execute was stalling it");

   assert property (empty_after_flush)
   else $error("Lane output still valid one cycle after a flush");

   assert property (read_starts_uop)
   else $error("Register file read started without a micro-op entering the lane");

endmodule

bind rr_lane reg_read_unit_assertions u_lane_assert
(
   .clk       (clk),
   .rst_n     (rst_n),
   .flush     (flush),
   .rd_en     (rd_en),
   .out_uop   (out_uop),
   .out_valid (out_valid),
   .out_ready (out_ready)
);

/* verif/reg_read_unit_tb.sv */
// Register-read stage testbench
`timescale 1ns/1ps

module reg_read_unit_tb;
   import cpu_cfg_pkg::*;
   import uop_pkg::*;

   localparam int reset_cycles = 4;

   // One stimulus row
   typedef struct packed {
      logic              lane;
      alu_opc_e          alu;
      bru_opc_e          bru;
      logic [prf_aw-1:0] prs1;
      logic              re1;
      logic [prf_aw-1:0] prs2;
      logic              re2;
      logic [prf_aw-1:0] prd;
      logic              wb_we;
      logic [prf_aw-1:0] wb_addr;
      logic [3:0]        stall;   // Cycles execute refuses the uop
      logic              flush;
   } row_t;

   logic                          clk;
   logic                          rst_n;
   logic                          flush;
   rr_uop_t [issue_lanes-1:0]     ro_uop;
   logic [issue_lanes-1:0]        ro_valid;
   logic [issue_lanes-1:0]        ro_ready;
   prf_wb_t                       wb;
   ex_uop_t [issue_lanes-1:0]     ex_uop;
   logic [issue_lanes-1:0]        ex_valid;
   logic [issue_lanes-1:0]        ex_ready;

   row_t              table_q [$];
   logic              table_ready = 1'b0;
   logic [31:0]       lfsr_q = 32'he5d1bf52;
   logic [data_w-1:0] model [prf_depth];          // Reference register contents
   ex_uop_t           sb_q [issue_lanes][$];       // Expected uops per lane
   int                stall_cnt [issue_lanes];
   int                accepted = 0;
   int                drained  = 0;
   int                dropped  = 0;
   logic              flush_seen = 1'b0;

   reg_read_unit UUT
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (flush),
      .ro_uop   (ro_uop),
      .ro_valid (ro_valid),
      .ro_ready (ro_ready),
      .wb       (wb),
      .ex_uop   (ex_uop),
      .ex_valid (ex_valid),
      .ex_ready (ex_ready)
   );

   initial
   begin : clock_gen
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [data_w-1:0] rand_bits(input int n);
      logic [data_w-1:0] val;
      logic              fb;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         val    = {val[data_w-2:0], fb};
      end
      return val;
   endfunction

   task automatic add_row(input int lane, input alu_opc_e alu, input bru_opc_e bru,
                          input int prs1, input int re1, input int prs2, input int re2,
                          input int prd, input int wb_we, input int wb_addr,
                          input int stall, input int flush_row);
      row_t r;
      r.lane    = 1'(lane);
      r.alu     = alu;
      r.bru     = bru;
      r.prs1    = prf_aw'(prs1);
      r.re1     = 1'(re1);
      r.prs2    = prf_aw'(prs2);
      r.re2     = 1'(re2);
      r.prd     = prf_aw'(prd);
      r.wb_we   = 1'(wb_we);
      r.wb_addr = prf_aw'(wb_addr);
      r.stall   = 4'(stall);
      r.flush   = 1'(flush_row);
      table_q.push_back(r);
   endtask

   task automatic build_table();
      //      ln alu       bru       rs1 re rs2 re  rd wbv wba stl fl
      add_row(0, ALU_ADD,  BRU_NONE,  0, 1,  0, 1,  1, 1,  1, 0, 0); // r0 reads zero
      add_row(1, ALU_SUB,  BRU_NONE,  1, 1,  2, 1,  2, 1,  2, 0, 0); // r2 forwarded
      add_row(0, ALU_AND,  BRU_NONE,  2, 1,  1, 1,  3, 1,  3, 4, 0);
      add_row(1, ALU_OR,   BRU_NONE,  3, 1,  3, 0,  4, 1,  4, 2, 0); // Second read off
      add_row(0, ALU_XOR,  BRU_NONE,  4, 1,  3, 1,  5, 1,  0, 0, 0); // Write to r0 ignored
      add_row(1, ALU_NONE, BRU_BEQ,   0, 1,  4, 1,  0, 1,  5, 3, 0);
      add_row(0, ALU_SLL,  BRU_NONE,  5, 1,  5, 1,  6, 1,  5, 0, 0);
      add_row(1, ALU_SRL,  BRU_NONE,  6, 0,  6, 0,  7, 0,  0, 6, 0); // No reads
      add_row(0, ALU_SLT,  BRU_NONE,  1, 1,  4, 1,  8, 1,  6, 5, 0);
      add_row(1, ALU_NONE, BRU_JMP,   6, 1,  2, 1,  9, 1,  7, 0, 0);
      add_row(0, ALU_ADD,  BRU_NONE,  7, 1,  6, 1, 10, 0,  0, 0, 1); // Flush
      add_row(1, ALU_SUB,  BRU_NONE,  7, 1,  7, 1, 11, 1,  7, 2, 0);
      add_row(0, ALU_NONE, BRU_BNE,  63, 1, 62, 1,  0, 1, 63, 3, 0);
      add_row(1, ALU_NONE, BRU_BLT,  63, 1,  1, 1,  0, 1, 62, 4, 0);
      add_row(0, ALU_AND,  BRU_NONE, 62, 1, 63, 1, 12, 1, 32, 0, 0);
      add_row(1, ALU_NONE, BRU_BGE,  32, 1,  5, 1,  0, 0,  0, 1, 1); // Flush with lane 0 busy
      add_row(0, ALU_OR,   BRU_NONE, 32, 1, 62, 1, 13, 1, 33, 7, 0);
      add_row(1, ALU_XOR,  BRU_NONE, 33, 1, 32, 1, 14, 1,  1, 5, 0);
      add_row(0, ALU_SLL,  BRU_NONE,  1, 1, 33, 1, 15, 1,  2, 0, 0);
      add_row(1, ALU_SRL,  BRU_NONE,  2, 1,  1, 0, 16, 1, 33, 0, 0);
      add_row(0, ALU_SLT,  BRU_NONE, 33, 1,  2, 1, 17, 0,  0, 2, 0);
      add_row(1, ALU_ADD,  BRU_NONE,  3, 1,  4, 1, 18, 0,  0, 0, 1);
      add_row(0, ALU_SUB,  BRU_NONE,  5, 1,  6, 1, 19, 0,  0, 0, 0);
      add_row(1, ALU_AND,  BRU_NONE,  7, 1, 63, 1, 20, 0,  0, 0, 0);
   endtask

   function automatic rr_uop_t build_uop(input row_t r, input int idx);
      rr_uop_t u;
      u            = '0;
      u.alu_opc    = r.alu;
      u.bru_opc    = r.bru;
      u.lsu_op     = idx[0];
      u.epu_op     = idx[1];
      u.fe         = fe_w'(idx);
      u.pc         = pc_w'(rand_bits(pc_w));
      u.pred_taken = idx[2];
      u.pred_tgt   = pc_w'(rand_bits(pc_w));
      u.imm        = rand_bits(data_w);
      u.prd        = r.prd;
      u.prd_we     = (r.prd != '0);
      u.prs1       = r.prs1;
      u.prs1_re    = r.re1;
      u.prs2       = r.prs2;
      u.prs2_re    = r.re2;
      u.rob_id     = rob_id_w'(idx);
      u.rob_bank   = rob_bank_w'(idx >> rob_id_w);
      return u;
   endfunction

   // Operand as seen at the accepting edge
   function automatic logic [data_w-1:0] expect_operand(input logic re,
                                                        input logic [prf_aw-1:0] addr,
                                                        input prf_wb_t w);
      if (!re || addr == '0)
         return '0;
      if (w.valid && w.addr == addr)
         return w.data;
      return model[addr];
   endfunction

   function automatic ex_uop_t expected_uop(input rr_uop_t u, input prf_wb_t w);
      ex_uop_t e;
      e            = '0;
      e.alu_opc    = u.alu_opc;
      e.bru_opc    = u.bru_opc;
      e.lsu_op     = u.lsu_op;
      e.epu_op     = u.epu_op;
      e.fe         = u.fe;
      e.pc         = u.pc;
      e.pred_taken = u.pred_taken;
      e.pred_tgt   = u.pred_tgt;
      e.imm        = u.imm;
      e.prd        = u.prd;
      e.prd_we     = u.prd_we;
      e.operand1   = expect_operand(u.prs1_re, u.prs1, w);
      e.operand2   = expect_operand(u.prs2_re, u.prs2, w);
      e.rob_id     = u.rob_id;
      e.rob_bank   = u.rob_bank;
      return e;
   endfunction

   task automatic check_uop(input int lane, input ex_uop_t exp, input ex_uop_t got);
      assert (got.operand1 == exp.operand1)
      else fail_run($sformatf("Mismatch ex_uop[%0d].operand1 expected %h got %h",
                              lane, exp.operand1, got.operand1));
      assert (got.operand2 == exp.operand2)
      else fail_run($sformatf("Mismatch ex_uop[%0d].operand2 expected %h got %h",
                              lane, exp.operand2, got.operand2));
      assert (got.imm == exp.imm)
      else fail_run($sformatf("Mismatch ex_uop[%0d].imm expected %h got %h",
                              lane, exp.imm, got.imm));
      assert (got == exp)   // Remaining payload fields
      else fail_run($sformatf("Mismatch ex_uop[%0d] expected %h got %h", lane, exp, got));
   endtask

   function automatic int held_count();
      int n;
      n = 0;
      for (int l = 0; l < issue_lanes; l++)
         n += sb_q[l].size();
      return n;
   endfunction

   task automatic drive_ex_ready();
      for (int l = 0; l < issue_lanes; l++)
      begin
         if (stall_cnt[l] > 0)
         begin
            ex_ready[l] = 1'b0;
            stall_cnt[l]--;
         end
         else
            ex_ready[l] = (rand_bits(2) != '0);   // Ready three cycles in four
      end
   endtask

   // Scoreboard and handshake checks on the pre-edge values
   always @(posedge clk)
   begin : monitor
      if (rst_n)
      begin
         for (int l = 0; l < issue_lanes; l++)
         begin : lane_check
            logic exp_ready;
            // Lane is busy while its scoreboard holds a uop
            exp_ready = !flush && (sb_q[l].size() == 0 || ex_ready[l]);
            assert (ro_ready[l] == exp_ready)
            else fail_run($sformatf("Mismatch ro_ready[%0d] expected %h got %h",
                                    l, exp_ready, ro_ready[l]));
            if (flush_seen)
               assert (!ex_valid[l])
               else fail_run($sformatf("Lane %0d kept a micro-op across a flush", l));
            if (ex_valid[l])
            begin
               assert (sb_q[l].size() != 0)
               begin
                  check_uop(l, sb_q[l][0], ex_uop[l]);
                  if (ex_ready[l])
                  begin
                     void'(sb_q[l].pop_front());
                     drained++;
                  end
               end
               else fail_run($sformatf("Lane %0d presented a micro-op never accepted", l));
            end
            else
               assert (sb_q[l].size() == 0)
               else fail_run($sformatf("Lane %0d lost an accepted micro-op", l));
            if (ro_valid[l] && ro_ready[l])
            begin
               sb_q[l].push_back(expected_uop(ro_uop[l], wb));
               accepted++;
            end
            if (flush)
            begin
               dropped += sb_q[l].size();
               sb_q[l].delete();
            end
         end
         if (wb.valid && wb.addr != '0)
            model[wb.addr] = wb.data;
         flush_seen = flush;
      end
   end

   initial
   begin : watchdog
      wait (table_ready);
      repeat (table_q.size() * 20 + reset_cycles) @(posedge clk);
      fail_run("Watchdog expired before the stage drained all micro-ops");
   end

   initial
   begin : main
      int                     next_row;
      logic [issue_lanes-1:0] pend;
      int                     pend_stall [issue_lanes];
      logic                   wb_used;
      row_t                   cur;

      rst_n    = 1'b0;
      flush    = 1'b0;
      ro_uop   = '0;
      ro_valid = '0;
      wb       = '0;
      ex_ready = '0;
      pend     = '0;
      next_row = 0;
      for (int l = 0; l < issue_lanes; l++)
      begin
         stall_cnt[l]  = 0;
         pend_stall[l] = 0;
      end
      for (int r = 0; r < prf_depth; r++)
         model[r] = '0;
      build_table();
      table_ready = 1'b1;

      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      assert (ex_valid == '0)
      else fail_run($sformatf("Mismatch ex_valid expected %h got %h", 2'b00, ex_valid));
      assert (ro_ready == '1)
      else fail_run($sformatf("Mismatch ro_ready expected %h got %h", 2'b11, ro_ready));

      while (next_row < table_q.size() || pend != '0)
      begin
         @(negedge clk);
         flush   = 1'b0;
         wb      = '0;
         wb_used = 1'b0;
         ro_valid = ro_valid & pend;   // Accepted rows leave the bus
         // Rows go out in table order, one per free lane, one write per cycle
         while (next_row < table_q.size() && !pend[table_q[next_row].lane] &&
                !(wb_used && table_q[next_row].wb_we))
         begin
            cur                  = table_q[next_row];
            ro_uop[cur.lane]     = build_uop(cur, next_row);
            ro_valid[cur.lane]   = 1'b1;
            pend[cur.lane]       = 1'b1;
            pend_stall[cur.lane] = int'(cur.stall);
            if (cur.wb_we)
            begin
               wb.valid = 1'b1;
               wb.addr  = cur.wb_addr;
               wb.data  = rand_bits(data_w);
               wb_used  = 1'b1;
            end
            if (cur.flush)
               flush = 1'b1;
            next_row++;
         end
         drive_ex_ready();
         @(posedge clk);
         for (int l = 0; l < issue_lanes; l++)
         begin
            if (ro_valid[l] && ro_ready[l])
            begin
               pend[l]      = 1'b0;
               stall_cnt[l] = pend_stall[l];   // Hold the new uop at execute
            end
         end
      end

      // Let both lanes drain
      do
      begin
         @(negedge clk);
         flush    = 1'b0;
         wb       = '0;
         ro_valid = '0;
         drive_ex_ready();
      end while (held_count() != 0);
      @(negedge clk);

      $display("Accepted %0d, drained %0d, dropped %0d", accepted, drained, dropped);
      if (accepted == drained + dropped && held_count() == 0)
      begin
         $display("Finished with no errors");
         $finish;
      end
      else
         fail_run("Accepted micro-ops do not match those drained and flushed");
   end

endmodule
